// ==== src/exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// datapath and instruction widths, fixed rv64
`define EXEC_XLEN 64
`define EXEC_ILEN 32

// machine csr addresses, from inst[31:20]
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from m-mode
`define MCAUSE_ECALL_M 11

// sequential fetch step
`define PC_STEP 4

`endif

// ==== src/exec_pkg.sv ====
`include "exec_macros.svh"

package exec_pkg;

    // decoded operation, one per instruction flavour
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // immediate forms, no subi in the isa
        OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU,
        OP_XORI, OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI,
        // 32-bit word ops, result sign extended
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD, OP_STORE,
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET, OP_NOP
    } exec_op_e;

    // alu function select
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND
    } alu_mode_e;

    // instruction from decode
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_ILEN-1:0] inst;
        exec_op_e              op;
        logic [`EXEC_XLEN-1:0] src_a;
        // src_b also carries old csr value, mtvec or mepc
        logic [`EXEC_XLEN-1:0] src_b;
        logic [`EXEC_XLEN-1:0] imm;
    } ex_req_t;

    // result toward memory stage
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_ILEN-1:0] inst;
        exec_op_e              op;
        logic [`EXEC_XLEN-1:0] alu_out;
        logic [`EXEC_XLEN-1:0] store_data;
    } ex_resp_t;

    // alu command
    typedef struct packed {
        alu_mode_e             mode;
        logic                  word;
        logic [`EXEC_XLEN-1:0] op_a;
        logic [`EXEC_XLEN-1:0] op_b;
    } alu_req_t;

    // next pc to fetch
    typedef struct packed {
        logic                  update;
        logic [`EXEC_XLEN-1:0] dnpc;
    } redirect_t;

    // machine csr write port
    typedef struct packed {
        logic                  mtvec_en;
        logic                  mepc_en;
        logic                  mcause_en;
        logic                  mstatus_en;
        logic [`EXEC_XLEN-1:0] mtvec_data;
        logic [`EXEC_XLEN-1:0] mepc_data;
        logic [`EXEC_XLEN-1:0] mcause_data;
        logic [`EXEC_XLEN-1:0] mstatus_data;
    } csr_wr_t;

endpackage

// ==== src/exec_pipe_reg.sv ====
`include "exec_macros.svh"

module exec_pipe_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exec_pkg::ex_req_t     in_req,
    input  logic                  out_ready,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    output logic                  out_valid,
    output exec_pkg::ex_resp_t    out_resp,
    output exec_pkg::ex_req_t     held,
    output logic                  fire
);

    logic valid_q;

    // single slot, stage advances only when downstream takes
    assign in_ready = out_ready;

    // valid bit, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // instruction payload, held while stalled
    always_ff @(posedge clk) begin
        if (in_ready) begin
            held <= in_req;
        end
    end

    assign out_valid = valid_q;
    // hand-off to memory stage, side effects act here once
    assign fire = valid_q & out_ready;

    // result bundle, stable under back-pressure since held is
    assign out_resp.pc         = held.pc;
    assign out_resp.inst       = held.inst;
    assign out_resp.op         = held.op;
    assign out_resp.alu_out    = alu_result;
    assign out_resp.store_data = held.src_b;

endmodule

// ==== src/operand_mux.sv ====
module operand_mux (
    input  exec_pkg::ex_req_t  held,
    output exec_pkg::alu_req_t alu_req
);

    // operand a: zero, pc or src_a
    always_comb begin
        case (held.op)
            exec_pkg::OP_LUI: alu_req.op_a = '0;
            // pc-relative targets
            exec_pkg::OP_AUIPC, exec_pkg::OP_JAL,
            exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
            exec_pkg::OP_BLT, exec_pkg::OP_BGE,
            exec_pkg::OP_BLTU, exec_pkg::OP_BGEU: alu_req.op_a = held.pc;
            default: alu_req.op_a = held.src_a;
        endcase
    end

    // operand b: imm or src_b
    always_comb begin
        case (held.op)
            exec_pkg::OP_ADDI, exec_pkg::OP_SLLI, exec_pkg::OP_SLTI,
            exec_pkg::OP_SLTIU, exec_pkg::OP_XORI, exec_pkg::OP_SRLI,
            exec_pkg::OP_SRAI, exec_pkg::OP_ORI, exec_pkg::OP_ANDI,
            exec_pkg::OP_ADDIW, exec_pkg::OP_SLLIW,
            exec_pkg::OP_SRLIW, exec_pkg::OP_SRAIW,
            exec_pkg::OP_LUI, exec_pkg::OP_AUIPC,
            exec_pkg::OP_JAL, exec_pkg::OP_JALR,
            exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
            exec_pkg::OP_BLT, exec_pkg::OP_BGE,
            exec_pkg::OP_BLTU, exec_pkg::OP_BGEU,
            exec_pkg::OP_LOAD, exec_pkg::OP_STORE: alu_req.op_b = held.imm;
            // csrrs: old csr value sits in src_b
            default: alu_req.op_b = held.src_b;
        endcase
    end

    // alu function, add covers address and target math
    always_comb begin
        case (held.op)
            exec_pkg::OP_SUB, exec_pkg::OP_SUBW: alu_req.mode = exec_pkg::ALU_SUB;
            exec_pkg::OP_SLL, exec_pkg::OP_SLLI,
            exec_pkg::OP_SLLW, exec_pkg::OP_SLLIW: alu_req.mode = exec_pkg::ALU_SLL;
            exec_pkg::OP_SRL, exec_pkg::OP_SRLI,
            exec_pkg::OP_SRLW, exec_pkg::OP_SRLIW: alu_req.mode = exec_pkg::ALU_SRL;
            exec_pkg::OP_SRA, exec_pkg::OP_SRAI,
            exec_pkg::OP_SRAW, exec_pkg::OP_SRAIW: alu_req.mode = exec_pkg::ALU_SRA;
            exec_pkg::OP_SLT, exec_pkg::OP_SLTI: alu_req.mode = exec_pkg::ALU_SLT;
            exec_pkg::OP_SLTU, exec_pkg::OP_SLTIU: alu_req.mode = exec_pkg::ALU_SLTU;
            exec_pkg::OP_XOR, exec_pkg::OP_XORI: alu_req.mode = exec_pkg::ALU_XOR;
            // csrrs sets bits: src_a | old csr
            exec_pkg::OP_OR, exec_pkg::OP_ORI,
            exec_pkg::OP_CSRRS: alu_req.mode = exec_pkg::ALU_OR;
            exec_pkg::OP_AND, exec_pkg::OP_ANDI: alu_req.mode = exec_pkg::ALU_AND;
            default: alu_req.mode = exec_pkg::ALU_ADD;
        endcase
    end

    // word ops work on low half
    assign alu_req.word = held.op inside {
        exec_pkg::OP_ADDW, exec_pkg::OP_SUBW, exec_pkg::OP_SLLW,
        exec_pkg::OP_SRLW, exec_pkg::OP_SRAW, exec_pkg::OP_ADDIW,
        exec_pkg::OP_SLLIW, exec_pkg::OP_SRLIW, exec_pkg::OP_SRAIW
    };

endmodule

// ==== src/int_alu.sv ====
`include "exec_macros.svh"

module int_alu (
    input  exec_pkg::alu_req_t    alu_req,
    output logic [`EXEC_XLEN-1:0] result
);

    logic [5:0]                  shamt;
    logic [`EXEC_XLEN-1:0]       srl_in;
    logic signed [`EXEC_XLEN-1:0] sra_in;
    logic [`EXEC_XLEN-1:0]       raw;

    // 6-bit shift amount, 5-bit in word mode
    assign shamt = alu_req.word ? {1'b0, alu_req.op_b[4:0]} : alu_req.op_b[5:0];

    // word shifts see only the low 32 bits of a
    assign srl_in = alu_req.word ? {32'b0, alu_req.op_a[31:0]} : alu_req.op_a;
    // sign of bit 31 shifted in for sraw
    assign sra_in = alu_req.word ? {{32{alu_req.op_a[31]}}, alu_req.op_a[31:0]}
                                 : alu_req.op_a;

    always_comb begin
        case (alu_req.mode)
            exec_pkg::ALU_SUB:  raw = alu_req.op_a - alu_req.op_b;
            exec_pkg::ALU_SLL:  raw = alu_req.op_a << shamt;
            exec_pkg::ALU_SRL:  raw = srl_in >> shamt;
            // sra_in signed, shamt self-determined
            exec_pkg::ALU_SRA:  raw = sra_in >>> shamt;
            exec_pkg::ALU_SLT:
                raw = `EXEC_XLEN'($signed(alu_req.op_a) < $signed(alu_req.op_b));
            exec_pkg::ALU_SLTU: raw = `EXEC_XLEN'(alu_req.op_a < alu_req.op_b);
            exec_pkg::ALU_XOR:  raw = alu_req.op_a ^ alu_req.op_b;
            exec_pkg::ALU_OR:   raw = alu_req.op_a | alu_req.op_b;
            exec_pkg::ALU_AND:  raw = alu_req.op_a & alu_req.op_b;
            default:            raw = alu_req.op_a + alu_req.op_b;
        endcase
    end

    // word result sign extended from bit 31
    assign result = alu_req.word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// ==== src/branch_resolve.sv ====
`include "exec_macros.svh"

module branch_resolve (
    input  exec_pkg::ex_req_t     held,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    input  logic                  fire,
    output exec_pkg::redirect_t   redirect
);

    logic [`EXEC_XLEN-1:0] snpc;
    logic                  taken;
    logic                  is_ctrl;

    // fall-through pc
    assign snpc = held.pc + `EXEC_XLEN'(`PC_STEP);

    // branch condition on raw sources, alu busy with target
    always_comb begin
        case (held.op)
            exec_pkg::OP_BEQ:  taken = held.src_a == held.src_b;
            exec_pkg::OP_BNE:  taken = held.src_a != held.src_b;
            exec_pkg::OP_BLT:  taken = $signed(held.src_a) < $signed(held.src_b);
            exec_pkg::OP_BGE:  taken = $signed(held.src_a) >= $signed(held.src_b);
            exec_pkg::OP_BLTU: taken = held.src_a < held.src_b;
            exec_pkg::OP_BGEU: taken = held.src_a >= held.src_b;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        case (held.op)
            exec_pkg::OP_JAL:  redirect.dnpc = alu_result;
            // jalr target lsb forced low
            exec_pkg::OP_JALR: redirect.dnpc = {alu_result[`EXEC_XLEN-1:1], 1'b0};
            exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
            exec_pkg::OP_BLT, exec_pkg::OP_BGE,
            exec_pkg::OP_BLTU, exec_pkg::OP_BGEU:
                redirect.dnpc = taken ? alu_result : snpc;
            // trap vector or return address, read by decode
            exec_pkg::OP_ECALL, exec_pkg::OP_MRET: redirect.dnpc = held.src_b;
            default: redirect.dnpc = snpc;
        endcase
    end

    // not-taken branches still redirect, to snpc
    assign is_ctrl = held.op inside {
        exec_pkg::OP_JAL, exec_pkg::OP_JALR,
        exec_pkg::OP_BEQ, exec_pkg::OP_BNE, exec_pkg::OP_BLT,
        exec_pkg::OP_BGE, exec_pkg::OP_BLTU, exec_pkg::OP_BGEU,
        exec_pkg::OP_ECALL, exec_pkg::OP_MRET
    };

    // one strobe per instruction, at hand-off
    assign redirect.update = fire & is_ctrl;

endmodule

// ==== src/csr_write_ctrl.sv ====
`include "exec_macros.svh"

module csr_write_ctrl (
    input  exec_pkg::ex_req_t     held,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    input  logic                  fire,
    output exec_pkg::csr_wr_t     csr_wr
);

    logic [11:0]           csr_addr;
    logic                  is_csr_op;
    logic [`EXEC_XLEN-1:0] csr_data;

    // csr number in the i-type immediate field
    assign csr_addr  = held.inst[31:20];
    assign is_csr_op = (held.op == exec_pkg::OP_CSRRW) || (held.op == exec_pkg::OP_CSRRS);
    // csrrw: plain src_a, csrrs: alu or with old value
    assign csr_data  = (held.op == exec_pkg::OP_CSRRW) ? held.src_a : alu_result;

    always_comb begin
        // all quiet unless firing, data zero when disabled
        csr_wr = '0;
        if (fire && is_csr_op) begin
            case (csr_addr)
                `CSR_MTVEC: begin
                    csr_wr.mtvec_en   = 1'b1;
                    csr_wr.mtvec_data = csr_data;
                end
                `CSR_MEPC: begin
                    csr_wr.mepc_en   = 1'b1;
                    csr_wr.mepc_data = csr_data;
                end
                `CSR_MCAUSE: begin
                    csr_wr.mcause_en   = 1'b1;
                    csr_wr.mcause_data = csr_data;
                end
                `CSR_MSTATUS: begin
                    csr_wr.mstatus_en   = 1'b1;
                    csr_wr.mstatus_data = csr_data;
                end
                // unknown address, nothing written
                default: ;
            endcase
        end else if (fire && held.op == exec_pkg::OP_ECALL) begin
            // trap entry: save pc and cause
            csr_wr.mepc_en     = 1'b1;
            csr_wr.mepc_data   = held.pc;
            csr_wr.mcause_en   = 1'b1;
            csr_wr.mcause_data = `EXEC_XLEN'(`MCAUSE_ECALL_M);
        end
    end

endmodule

// ==== src/exec_stage.sv ====
`include "exec_macros.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst,
    // from decode
    input  logic                in_valid,
    output logic                in_ready,
    input  exec_pkg::ex_req_t   in_req,
    // to memory stage
    output logic                out_valid,
    input  logic                out_ready,
    output exec_pkg::ex_resp_t  out_resp,
    // to fetch and csr file
    output exec_pkg::redirect_t redirect,
    output exec_pkg::csr_wr_t   csr_wr
);

    exec_pkg::ex_req_t     held;
    exec_pkg::alu_req_t    alu_req;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  fire;

    // stage register and handshake
    exec_pipe_reg pipe_reg_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_ready  (out_ready),
        .alu_result (alu_result),
        .out_valid  (out_valid),
        .out_resp   (out_resp),
        .held       (held),
        .fire       (fire)
    );

    operand_mux operand_mux_i (
        .held    (held),
        .alu_req (alu_req)
    );

    int_alu int_alu_i (
        .alu_req (alu_req),
        .result  (alu_result)
    );

    // jump, branch and trap targets
    branch_resolve branch_resolve_i (
        .held       (held),
        .alu_result (alu_result),
        .fire       (fire),
        .redirect   (redirect)
    );

    csr_write_ctrl csr_write_ctrl_i (
        .held       (held),
        .alu_result (alu_result),
        .fire       (fire),
        .csr_wr     (csr_wr)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // two rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== testbench/exec_stage_tb.sv ====
`include "exec_macros.svh"

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic                out_valid;
    logic                out_ready;
    exec_pkg::ex_req_t   in_req;
    exec_pkg::ex_resp_t  out_resp;
    exec_pkg::redirect_t redirect;
    exec_pkg::csr_wr_t   csr_wr;

    // reference model state
    exec_pkg::ex_req_t   pending[$];
    exec_pkg::ex_req_t   model_req = '0;
    logic                model_valid = 1'b0;
    exec_pkg::ex_resp_t  exp_resp;
    exec_pkg::redirect_t exp_redirect;
    exec_pkg::csr_wr_t   exp_csr;
    logic                side_effect;

    int          seed = 32'h3a33_66b1;
    int          errors = 0;
    int          tests = 0;
    bit          stall = 1'b0;
    string       test_name = "reset";
    logic [63:0] next_pc = 64'h8000_0000;
    event        hang_ev;

    tb_clock_gen clock_gen_i (.clk(clk), .rst(rst));

    exec_stage exec_stage_i (.*);

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic bit is_ctrl(input exec_pkg::exec_op_e op);
        return op inside {exec_pkg::OP_JAL, exec_pkg::OP_JALR, exec_pkg::OP_BEQ,
            exec_pkg::OP_BNE, exec_pkg::OP_BLT, exec_pkg::OP_BGE, exec_pkg::OP_BLTU,
            exec_pkg::OP_BGEU, exec_pkg::OP_ECALL, exec_pkg::OP_MRET};
    endfunction

    // expected alu_out from the isa meaning of each op
    function automatic logic [63:0] model_alu(input exec_pkg::ex_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        a = r.src_a;
        b = r.src_b;
        if (r.op inside {exec_pkg::OP_ADDI, exec_pkg::OP_SLLI, exec_pkg::OP_SLTI,
                exec_pkg::OP_SLTIU, exec_pkg::OP_XORI, exec_pkg::OP_SRLI, exec_pkg::OP_SRAI,
                exec_pkg::OP_ORI, exec_pkg::OP_ANDI, exec_pkg::OP_ADDIW, exec_pkg::OP_SLLIW,
                exec_pkg::OP_SRLIW, exec_pkg::OP_SRAIW, exec_pkg::OP_JALR,
                exec_pkg::OP_LOAD, exec_pkg::OP_STORE})
            b = r.imm;
        case (r.op)
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_SLL, exec_pkg::OP_SLLI: return a << b[5:0];
            exec_pkg::OP_SRL, exec_pkg::OP_SRLI: return a >> b[5:0];
            exec_pkg::OP_SRA, exec_pkg::OP_SRAI: return $signed(a) >>> b[5:0];
            exec_pkg::OP_SLT, exec_pkg::OP_SLTI: return {63'b0, $signed(a) < $signed(b)};
            exec_pkg::OP_SLTU, exec_pkg::OP_SLTIU: return {63'b0, a < b};
            exec_pkg::OP_XOR, exec_pkg::OP_XORI: return a ^ b;
            // csrrs sets bits of the old value
            exec_pkg::OP_OR, exec_pkg::OP_ORI, exec_pkg::OP_CSRRS: return a | b;
            exec_pkg::OP_AND, exec_pkg::OP_ANDI: return a & b;
            exec_pkg::OP_ADDW, exec_pkg::OP_ADDIW: return sext32(a[31:0] + b[31:0]);
            exec_pkg::OP_SUBW: return sext32(a[31:0] - b[31:0]);
            exec_pkg::OP_SLLW, exec_pkg::OP_SLLIW: return sext32(a[31:0] << b[4:0]);
            exec_pkg::OP_SRLW, exec_pkg::OP_SRLIW: return sext32(a[31:0] >> b[4:0]);
            exec_pkg::OP_SRAW, exec_pkg::OP_SRAIW:
                return sext32($signed(a[31:0]) >>> b[4:0]);
            exec_pkg::OP_LUI: return r.imm;
            // pc-relative results and targets
            exec_pkg::OP_AUIPC, exec_pkg::OP_JAL, exec_pkg::OP_BEQ, exec_pkg::OP_BNE,
            exec_pkg::OP_BLT, exec_pkg::OP_BGE, exec_pkg::OP_BLTU, exec_pkg::OP_BGEU:
                return r.pc + r.imm;
            default: return a + b;
        endcase
    endfunction

    function automatic logic [63:0] model_dnpc(input exec_pkg::ex_req_t r);
        logic taken;
        case (r.op)
            exec_pkg::OP_BEQ:  taken = r.src_a == r.src_b;
            exec_pkg::OP_BNE:  taken = r.src_a != r.src_b;
            exec_pkg::OP_BLT:  taken = $signed(r.src_a) < $signed(r.src_b);
            exec_pkg::OP_BGE:  taken = $signed(r.src_a) >= $signed(r.src_b);
            exec_pkg::OP_BLTU: taken = r.src_a < r.src_b;
            exec_pkg::OP_BGEU: taken = r.src_a >= r.src_b;
            default:           taken = 1'b0;
        endcase
        case (r.op)
            exec_pkg::OP_JAL: return r.pc + r.imm;
            exec_pkg::OP_JALR: return (r.src_a + r.imm) & ~64'd1;
            // trap vector or return address supplied by decode
            exec_pkg::OP_ECALL, exec_pkg::OP_MRET: return r.src_b;
            default: return taken ? r.pc + r.imm : r.pc + 64'(`PC_STEP);
        endcase
    endfunction

    function automatic exec_pkg::csr_wr_t model_csr(input exec_pkg::ex_req_t r, input bit fire);
        exec_pkg::csr_wr_t c;
        logic [63:0]       d;
        c = '0;
        d = (r.op == exec_pkg::OP_CSRRS) ? (r.src_a | r.src_b) : r.src_a;
        if (fire && r.op inside {exec_pkg::OP_CSRRW, exec_pkg::OP_CSRRS}) begin
            case (r.inst[31:20])
                `CSR_MTVEC: begin
                    c.mtvec_en = 1'b1;
                    c.mtvec_data = d;
                end
                `CSR_MEPC: begin
                    c.mepc_en = 1'b1;
                    c.mepc_data = d;
                end
                `CSR_MCAUSE: begin
                    c.mcause_en = 1'b1;
                    c.mcause_data = d;
                end
                `CSR_MSTATUS: begin
                    c.mstatus_en = 1'b1;
                    c.mstatus_data = d;
                end
                default: ;
            endcase
        end else if (fire && r.op == exec_pkg::OP_ECALL) begin
            c.mepc_en = 1'b1;
            c.mepc_data = r.pc;
            c.mcause_en = 1'b1;
            c.mcause_data = 64'(`MCAUSE_ECALL_M);
        end
        return c;
    endfunction

    // in-flight queue, one item at most since in_ready tracks out_ready
    always @(posedge clk) begin
        if (rst) begin
            pending.delete();
        end else begin
            if (model_valid && out_ready)
                void'(pending.pop_front());
            if (in_valid && out_ready)
                pending.push_back(in_req);
        end
        model_valid = pending.size() != 0;
        if (model_valid)
            model_req = pending[0];
    end

    always_comb begin
        exp_resp.pc = model_req.pc;
        exp_resp.inst = model_req.inst;
        exp_resp.op = model_req.op;
        exp_resp.alu_out = model_alu(model_req);
        exp_resp.store_data = model_req.src_b;
        exp_redirect.update = model_valid && out_ready && is_ctrl(model_req.op);
        exp_redirect.dnpc = model_dnpc(model_req);
        exp_csr = model_csr(model_req, model_valid && out_ready);
    end

    assign side_effect = redirect.update | csr_wr.mtvec_en | csr_wr.mepc_en
                       | csr_wr.mcause_en | csr_wr.mstatus_en;

    task automatic mismatch(input string what, input logic [263:0] exp,
                            input logic [263:0] act);
        errors++;
        $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    endtask

    task automatic complain(input string what);
        errors++;
        $display("ERROR %s: %s", test_name, what);
    endtask

    ready_chk: assert property (@(posedge clk) disable iff (rst) in_ready == out_ready)
        else mismatch("in_ready", $sampled(out_ready), $sampled(in_ready));
    valid_chk: assert property (@(posedge clk) disable iff (rst) out_valid == model_valid)
        else mismatch("out_valid", $sampled(model_valid), $sampled(out_valid));
    resp_chk: assert property (@(posedge clk) disable iff (rst)
        !model_valid || out_resp == exp_resp)
        else mismatch("out_resp", $sampled(exp_resp), $sampled(out_resp));
    update_chk: assert property (@(posedge clk) disable iff (rst)
        redirect.update == exp_redirect.update)
        else mismatch("redirect.update", $sampled(exp_redirect.update),
                      $sampled(redirect.update));
    dnpc_chk: assert property (@(posedge clk) disable iff (rst)
        !exp_redirect.update || redirect.dnpc == exp_redirect.dnpc)
        else mismatch("redirect.dnpc", $sampled(exp_redirect.dnpc), $sampled(redirect.dnpc));
    csr_chk: assert property (@(posedge clk) disable iff (rst) csr_wr == exp_csr)
        else mismatch("csr_wr", $sampled(exp_csr), $sampled(csr_wr));
    // stalled item must not move
    hold_chk: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_resp))
        else complain("out_resp changed while the output was stalled");
    fire_chk: assert property (@(posedge clk) disable iff (rst)
        side_effect |-> out_valid && out_ready)
        else complain("redirect or CSR write raised without a hand-off");

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic exec_pkg::ex_req_t make_req(input exec_pkg::exec_op_e op,
                                                   input logic [63:0] a,
                                                   input logic [63:0] b);
        exec_pkg::ex_req_t r;
        // sequential pc keeps every item distinct
        r.pc = next_pc;
        next_pc += 64'(`PC_STEP);
        r.inst = $random(seed);
        r.op = op;
        r.src_a = a;
        r.src_b = b;
        r.imm = rand64();
        return r;
    endfunction

    // present one item until taken, called on a falling edge
    task automatic send(input exec_pkg::ex_req_t r);
        bit accepted;
        int waited;
        accepted = 1'b0;
        waited = 0;
        in_req = r;
        in_valid = 1'b1;
        while (!accepted) begin
            if (stall)
                out_ready = ($random(seed) & 3) != 0;
            @(posedge clk);
            accepted = in_ready;
            @(negedge clk);
            waited++;
            if (!accepted && waited > 100) begin
                complain("instruction was never accepted");
                -> hang_ev;
                break;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        tests++;
    endtask

    // let the last item leave, then report
    task automatic end_test(input int errors_before);
        int waited;
        waited = 0;
        stall = 1'b0;
        out_ready = 1'b1;
        while (model_valid) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                complain("last instruction never left the stage");
                -> hang_ev;
                break;
            end
        end
        $display("test %s finished, %0d errors", test_name, errors - errors_before);
    endtask

    task automatic run_all();
        logic [11:0] addrs[5];
        int          waited;
        int          e;
        exec_pkg::ex_req_t r;
        addrs = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, 12'h7c0};
        waited = 0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
            waited++;
            if (waited > 10) begin
                complain("reset never released");
                -> hang_ev;
                break;
            end
        end

        // quiet after reset, then one nop
        begin_test("reset");
        e = errors;
        repeat (2) @(negedge clk);
        send(make_req(exec_pkg::OP_NOP, rand64(), rand64()));
        end_test(e);

        // ops 0..29 are alu ops, load and store sit at 38 and 39
        begin_test("alu");
        e = errors;
        for (int rep = 0; rep < 4; rep++) begin
            for (int i = 0; i < 32; i++)
                send(make_req(exec_pkg::exec_op_e'(i < 30 ? i : i + 8), rand64(), rand64()));
        end
        end_test(e);

        // jumps, branches, ecall, mret, nop; equal sources every other pass
        begin_test("control_flow");
        e = errors;
        for (int rep = 0; rep < 6; rep++) begin
            for (int i = 30; i <= 44; i++) begin
                if (i < 38 || i > 41) begin
                    r = make_req(exec_pkg::exec_op_e'(i), rand64(), rand64());
                    if (rep[0])
                        r.src_b = r.src_a;
                    send(r);
                end
            end
        end
        end_test(e);

        begin_test("csr");
        e = errors;
        foreach (addrs[k]) begin
            r = make_req(exec_pkg::OP_CSRRW, rand64(), rand64());
            r.inst[31:20] = addrs[k];
            send(r);
            r = make_req(exec_pkg::OP_CSRRS, rand64(), rand64());
            r.inst[31:20] = addrs[k];
            send(r);
        end
        send(make_req(exec_pkg::OP_ECALL, rand64(), rand64()));
        send(make_req(exec_pkg::OP_MRET, rand64(), rand64()));
        end_test(e);

        // random stalls on the output side
        begin_test("back_pressure");
        e = errors;
        stall = 1'b1;
        for (int n = 0; n < 60; n++)
            send(make_req(exec_pkg::exec_op_e'($unsigned($random(seed)) % 45),
                          rand64(), rand64()));
        end_test(e);
    endtask

    initial begin
        in_valid = 1'b0;
        in_req = '0;
        out_ready = 1'b1;
        fork
            run_all();
            @(hang_ev);
        join_any
        disable fork;
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== exec_stage.f ====
+incdir+src
src/exec_pkg.sv
src/exec_pipe_reg.sv
src/operand_mux.sv
src/int_alu.sv
src/branch_resolve.sv
src/csr_write_ctrl.sv
src/exec_stage.sv
testbench/tb_clock_gen.sv
testbench/exec_stage_tb.sv
